/* filelist.f */
+incdir+hdl
hdl/dfq_pkg.sv
hdl/fill_batch_if.sv
hdl/fill_req_fifo.sv
hdl/fill_req_drain.sv
hdl/dram_fill_queue.sv
dv/dram_fill_queue_properties.sv
dv/dram_fill_queue_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the DRAM fill queue testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
	--top-module dram_fill_queue_tb \
	-f filelist.f \
	-Mdir obj_dir

echo "Running simulation, log in sim.log"
./obj_dir/Vdram_fill_queue_tb > sim.log 2>&1
cat sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
	echo "Simulation failed"
	exit 1
fi
echo "Simulation passed"

/* dv/dram_fill_queue_tb.sv */
`timescale 1ns/100ps

`include "dfq_consts.svh"

module dram_fill_queue_tb;

	localparam int VALID_TIMEOUT = 50;
	localparam int DRAIN_LIMIT   = 400;

	logic                                 clk;
	logic                                 reset;
	logic                                 fill_push;
	dfq_pkg::bank_mask_t                  bank_fill_req;
	dfq_pkg::line_addr_t [`DFQ_BANKS-1:0] bank_fill_addr;
	logic                                 dram_pop;
	logic                                 dram_req_valid;
	dfq_pkg::bank_idx_t                   dram_req_bank;
	dfq_pkg::line_addr_t                  dram_req_addr;
	logic                                 queue_full;

	// Reference model, batches still queued plus the batch being served
	dfq_pkg::fill_batch_t model_q [$];
	dfq_pkg::fill_batch_t model_res;

	string test_name;
	int    test_errors;
	int    total_errors;
	int    tests_run;
	int    tests_failed;

	dram_fill_queue u_dram_fill_queue (
		.clk            (clk),
		.reset          (reset),
		.fill_push      (fill_push),
		.bank_fill_req  (bank_fill_req),
		.bank_fill_addr (bank_fill_addr),
		.queue_full     (queue_full),
		.dram_pop       (dram_pop),
		.dram_req_valid (dram_req_valid),
		.dram_req_bank  (dram_req_bank),
		.dram_req_addr  (dram_req_addr)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#2 clk = ~clk;
		end
	end

	task automatic check_bit(input string what, input logic exp, input logic act);
		if (act !== exp) begin
			$display("** Error [%s] %s: expected %0b, actual %0b", test_name, what, exp, act);
			test_errors++;
		end
	endtask

	task automatic check_bank(input dfq_pkg::bank_idx_t exp, input dfq_pkg::bank_idx_t act);
		if (act !== exp) begin
			$display("** Error [%s] dram_req_bank: expected %0d, actual %0d",
				test_name, exp, act);
			test_errors++;
		end
	endtask

	task automatic check_addr(input dfq_pkg::line_addr_t exp, input dfq_pkg::line_addr_t act);
		if (act !== exp) begin
			$display("** Error [%s] dram_req_addr: expected 0x%h, actual 0x%h",
				test_name, exp, act);
			test_errors++;
		end
	endtask

	// Lowest requesting bank, -1 when the mask is empty
	function automatic int lowest_bank(input dfq_pkg::bank_mask_t m);
		for (int i = 0; i < `DFQ_BANKS; i++) begin
			if (m[i]) begin
				return i;
			end
		end
		return -1;
	endfunction

	// Unfinished batch first, otherwise the queue head
	function automatic dfq_pkg::fill_batch_t model_current();
		dfq_pkg::fill_batch_t b;
		b = '0;
		if (model_res.mask != '0) begin
			b = model_res;
		end else if (model_q.size() > 0) begin
			b = model_q[0];
		end
		return b;
	endfunction

	function automatic dfq_pkg::fill_batch_t make_batch(input dfq_pkg::bank_mask_t m);
		dfq_pkg::fill_batch_t b;
		b.mask = m;
		for (int i = 0; i < `DFQ_BANKS; i++) begin
			b.addr[i] = dfq_pkg::line_addr_t'($urandom());
		end
		return b;
	endfunction

	function automatic dfq_pkg::bank_mask_t nonzero_mask();
		return dfq_pkg::bank_mask_t'($urandom_range(1, (1 << `DFQ_BANKS) - 1));
	endfunction

	// One clock: check outputs against the model, drive, then advance the model
	task automatic run_cycle(input logic push, input dfq_pkg::fill_batch_t b, input logic pop);
		dfq_pkg::fill_batch_t cur;
		dfq_pkg::bank_idx_t   idx;
		int                   bank;
		logic                 was_full;
		cur      = model_current();
		bank     = lowest_bank(cur.mask);
		idx      = dfq_pkg::bank_idx_t'(bank);
		was_full = (model_q.size() == `DFQ_DEPTH);
		check_bit("dram_req_valid", bank >= 0, dram_req_valid);
		check_bit("queue_full", was_full, queue_full);
		if (bank >= 0 && dram_req_valid) begin
			check_bank(idx, dram_req_bank);
			check_addr(cur.addr[idx], dram_req_addr);
		end
		fill_push      = push;
		bank_fill_req  = b.mask;
		bank_fill_addr = b.addr;
		dram_pop       = pop;
		@(posedge clk);
		if (pop && bank >= 0) begin
			if (model_res.mask == '0) begin
				model_res = model_q[0];
				model_q.delete(0);
			end
			model_res.mask[idx] = 1'b0;
		end else if (model_res.mask == '0 && model_q.size() > 0 && model_q[0].mask == '0) begin
			// Empty batch leaves without showing a request
			model_q.delete(0);
		end
		if (push && !was_full) begin
			model_q.push_back(b);
		end
		@(negedge clk);
	endtask

	task automatic wait_valid();
		int n;
		n = 0;
		while (!dram_req_valid && n < VALID_TIMEOUT) begin
			run_cycle(1'b0, '0, 1'b0);
			n++;
		end
		if (!dram_req_valid) begin
			$display("[%s] timeout: no request became valid within %0d cycles",
				test_name, VALID_TIMEOUT);
			test_errors++;
		end
	endtask

	// Pop with the given chance in percent until model and DUT are idle
	task automatic drain(input int pop_pct);
		int n;
		n = 0;
		while ((model_q.size() > 0 || model_res.mask != '0 || dram_req_valid) &&
				n < DRAIN_LIMIT) begin
			run_cycle(1'b0, '0, $urandom_range(0, 99) < pop_pct);
			n++;
		end
		if (model_q.size() > 0 || model_res.mask != '0 || dram_req_valid) begin
			$display("[%s] timeout: queue did not drain within %0d cycles",
				test_name, DRAIN_LIMIT);
			test_errors++;
		end
	endtask

	task automatic start_test(input string name);
		test_name   = name;
		test_errors = 0;
		tests_run++;
	endtask

	task automatic end_test();
		if (test_errors == 0) begin
			$display("Test %s: passed", test_name);
		end else begin
			$display("Test %s: failed with %0d errors", test_name, test_errors);
			tests_failed++;
		end
		total_errors += test_errors;
	endtask

	task automatic test_reset_state();
		start_test("reset_state");
		check_bit("dram_req_valid", 1'b0, dram_req_valid);
		check_bit("queue_full", 1'b0, queue_full);
		repeat (3) begin
			run_cycle(1'b0, '0, 1'b1);
		end
		check_bit("dram_req_valid", 1'b0, dram_req_valid);
		check_bit("queue_full", 1'b0, queue_full);
		end_test();
	endtask

	task automatic test_single_batch();
		dfq_pkg::fill_batch_t b;
		dfq_pkg::bank_mask_t  m;
		dfq_pkg::bank_idx_t   idx;
		int                   banks [3];
		start_test("single_batch");
		banks = '{1, 4, 6};
		m     = '0;
		m[1]  = 1'b1;
		m[4]  = 1'b1;
		m[6]  = 1'b1;
		b     = make_batch(m);
		run_cycle(1'b1, b, 1'b0);
		wait_valid();
		for (int k = 0; k < 3; k++) begin
			idx = dfq_pkg::bank_idx_t'(banks[k]);
			check_bit("dram_req_valid", 1'b1, dram_req_valid);
			check_bank(idx, dram_req_bank);
			check_addr(b.addr[idx], dram_req_addr);
			run_cycle(1'b0, '0, 1'b1);
		end
		check_bit("dram_req_valid", 1'b0, dram_req_valid);
		end_test();
	endtask

	task automatic test_back_pressure();
		start_test("back_pressure");
		repeat (3) begin
			run_cycle(1'b1, make_batch(nonzero_mask()), 1'b0);
		end
		wait_valid();
		drain(35);
		end_test();
	endtask

	task automatic test_full_drop();
		start_test("full_drop");
		for (int i = 0; i < `DFQ_DEPTH; i++) begin
			run_cycle(1'b1, make_batch(nonzero_mask()), 1'b0);
		end
		check_bit("queue_full", 1'b1, queue_full);
		// This batch must never reach the DRAM side
		run_cycle(1'b1, make_batch('1), 1'b0);
		check_bit("queue_full", 1'b1, queue_full);
		drain(100);
		check_bit("queue_full", 1'b0, queue_full);
		end_test();
	endtask

	task automatic test_zero_mask();
		start_test("zero_mask");
		run_cycle(1'b1, make_batch(nonzero_mask()), 1'b0);
		run_cycle(1'b1, make_batch('0), 1'b0);
		run_cycle(1'b1, make_batch(nonzero_mask()), 1'b0);
		drain(100);
		end_test();
	endtask

	task automatic test_random_stream();
		dfq_pkg::bank_mask_t m;
		logic                push;
		start_test("random_stream");
		for (int i = 0; i < 200; i++) begin
			push = ($urandom_range(0, 2) == 0);
			m    = ($urandom_range(0, 7) == 0) ? '0 : dfq_pkg::bank_mask_t'($urandom());
			run_cycle(push, make_batch(m), $urandom_range(0, 1) == 1);
		end
		drain(100);
		end_test();
	endtask

	initial begin
		void'($urandom(32'hf21bd7b3));
		reset          = 1'b1;
		fill_push      = 1'b0;
		bank_fill_req  = '0;
		bank_fill_addr = '0;
		dram_pop       = 1'b0;
		model_res      = '0;
		total_errors   = 0;
		tests_run      = 0;
		tests_failed   = 0;
		repeat (3) begin
			@(posedge clk);
		end
		@(negedge clk);
		reset = 1'b0;

		test_reset_state();
		test_single_batch();
		test_back_pressure();
		test_full_drop();
		test_zero_mask();
		test_random_stream();

		$display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed,
			total_errors);
		if (total_errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

	// Guard against a stuck run
	initial begin
		#200000;
		$display("Simulation did not finish within its time limit");
		$display("** FAIL **");
		$finish;
	end

endmodule

/* dv/dram_fill_queue_properties.sv */
`timescale 1ns/100ps

`include "dfq_consts.svh"

module dram_fill_queue_properties (
	input logic                clk,
	input logic                reset,
	input logic                dram_pop,
	input logic                dram_req_valid,
	input dfq_pkg::bank_idx_t  dram_req_bank,
	input dfq_pkg::line_addr_t dram_req_addr,
	input logic                queue_full
);

	// Both status levels come out of reset low
	reset_state_low: assert property (@(posedge clk)
		reset |=> (!queue_full && !dram_req_valid))
		else $error("queue_full or dram_req_valid high in the cycle after reset");

	// A request waiting for its pop keeps its bank and address
	req_held: assert property (@(posedge clk) disable iff (reset)
		(dram_req_valid && !dram_pop) |=> ($stable(dram_req_bank) && $stable(dram_req_addr)))
		else $error("DRAM request changed while waiting for its pop");

	// A slot frees up when a request leaves the FIFO head, or one cycle later
	// when an empty batch behind the last served request is thrown away
	full_falls_on_pop: assert property (@(posedge clk) disable iff (reset)
		($fell(queue_full) && !$past(reset)) |->
		($past(dram_req_valid && dram_pop) || $past(dram_req_valid && dram_pop, 2)))
		else $error("queue_full fell without a consumed request");

endmodule

bind dram_fill_queue dram_fill_queue_properties u_properties (
	.clk            (clk),
	.reset          (reset),
	.dram_pop       (dram_pop),
	.dram_req_valid (dram_req_valid),
	.dram_req_bank  (dram_req_bank),
	.dram_req_addr  (dram_req_addr),
	.queue_full     (queue_full)
);

/* hdl/dram_fill_queue.sv */
`timescale 1ns/100ps

`include "dfq_consts.svh"

module dram_fill_queue (
	input  logic                                 clk,
	input  logic                                 reset,

	// Bank side
	input  logic                                 fill_push,
	input  dfq_pkg::bank_mask_t                  bank_fill_req,
	input  dfq_pkg::line_addr_t [`DFQ_BANKS-1:0] bank_fill_addr,
	output logic                                 queue_full,

	// DRAM side
	input  logic                                 dram_pop,
	output logic                                 dram_req_valid,
	output dfq_pkg::bank_idx_t                   dram_req_bank,
	output dfq_pkg::line_addr_t                  dram_req_addr
);

	// Batch channel between storage and drain
	fill_batch_if #(
		.payload_t (dfq_pkg::fill_batch_t)
	) batch_q ();

	// Producer side of the channel
	assign batch_q.push       = fill_push;
	assign batch_q.wdata.mask = bank_fill_req;
	assign batch_q.wdata.addr = bank_fill_addr;

	// Back-pressure towards the banks
	assign queue_full = batch_q.full;

	// Storage stage
	fill_req_fifo #(
		.payload_t (dfq_pkg::fill_batch_t),
		.DEPTH     (`DFQ_DEPTH)
	) u_fifo (
		.clk   (clk),
		.reset (reset),
		.q     (batch_q.fifo)
	);

	// Drain stage, one request per bank in bank order
	fill_req_drain u_drain (
		.clk            (clk),
		.reset          (reset),
		.q              (batch_q.drain),
		.dram_pop       (dram_pop),
		.dram_req_valid (dram_req_valid),
		.dram_req_bank  (dram_req_bank),
		.dram_req_addr  (dram_req_addr)
	);

endmodule

/* hdl/fill_req_drain.sv */
`timescale 1ns/100ps

`include "dfq_consts.svh"

module fill_req_drain (
	input  logic                 clk,
	input  logic                 reset,
	fill_batch_if.drain          q,
	input  logic                 dram_pop,
	output logic                 dram_req_valid,
	output dfq_pkg::bank_idx_t   dram_req_bank,
	output dfq_pkg::line_addr_t  dram_req_addr
);

	// Unfinished part of the batch that left the FIFO
	dfq_pkg::bank_mask_t                  resid_mask;
	dfq_pkg::line_addr_t [`DFQ_BANKS-1:0] resid_addr;
	logic                                 resid_busy;

	// FIFO head
	logic                                 head_valid;
	logic                                 head_zero;
	dfq_pkg::bank_mask_t                  head_mask;

	// Batch currently being served
	dfq_pkg::bank_mask_t                  sel_mask;
	dfq_pkg::line_addr_t [`DFQ_BANKS-1:0] sel_addr;
	dfq_pkg::bank_idx_t                   sel_idx;
	dfq_pkg::bank_mask_t                  sel_onehot;
	dfq_pkg::bank_mask_t                  rest_mask;
	logic                                 sel_found;

	logic                                 take;
	logic                                 pop_head;

	assign resid_busy = |resid_mask;

	// Mask of an empty FIFO counts as no request
	assign head_valid = !q.empty;
	assign head_mask  = head_valid ? q.rdata.mask : '0;
	assign head_zero  = head_valid && (q.rdata.mask == '0);

	// The residual batch is finished before the head is touched
	assign sel_mask = resid_busy ? resid_mask : head_mask;
	assign sel_addr = resid_busy ? resid_addr : q.rdata.addr;

	// Lowest set bit wins
	always_comb begin
		sel_idx = '0;
		for (int i = `DFQ_BANKS - 1; i >= 0; i--) begin
			if (sel_mask[i]) begin
				sel_idx = dfq_pkg::bank_idx_t'(i);
			end
		end
	end

	assign sel_found  = |sel_mask;
	assign sel_onehot = dfq_pkg::bank_mask_t'(1) << sel_idx;
	assign rest_mask  = sel_mask & ~sel_onehot;

	// Request towards DRAM, combinational from head or residual
	assign dram_req_valid = sel_found;
	assign dram_req_bank  = sel_idx;
	assign dram_req_addr  = sel_addr[sel_idx];

	// A pop with nothing to show is ignored
	assign take = dram_pop && sel_found;

	// Head leaves the FIFO on its first served request,
	// or right away when it carries no request at all
	assign pop_head = !resid_busy && (take || head_zero);
	assign q.pop    = pop_head;

	// Remaining bits of the batch after each served request
	always_ff @(posedge clk) begin
		if (reset) begin
			resid_mask <= '0;
		end else if (take) begin
			resid_mask <= rest_mask;
		end
	end

	// Addresses are captured once, when the batch leaves the FIFO
	always_ff @(posedge clk) begin
		if (take && !resid_busy) begin
			resid_addr <= q.rdata.addr;
		end
	end

endmodule

/* hdl/fill_req_fifo.sv */
`timescale 1ns/100ps

`include "dfq_consts.svh"

module fill_req_fifo #(
	parameter type payload_t = logic,
	parameter int  DEPTH     = `DFQ_DEPTH
) (
	input logic        clk,
	input logic        reset,
	fill_batch_if.fifo q
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	payload_t         mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] wr_ptr_next;
	logic [PTR_W-1:0] rd_ptr_next;
	logic [CNT_W-1:0] count;
	logic             push_ok;
	logic             pop_ok;

	// A push while full is dropped, a pop while empty is ignored
	assign push_ok = q.push && !q.full;
	assign pop_ok  = q.pop && !q.empty;

	// Wrap explicitly so the pointers stay inside the buffer
	assign wr_ptr_next = (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
	assign rd_ptr_next = (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);

	// Status comes straight from the occupancy count
	assign q.full  = (count == CNT_W'(DEPTH));
	assign q.empty = (count == '0);

	// First word fall through, the head is always on rdata
	assign q.rdata = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
		end else if (push_ok) begin
			wr_ptr <= wr_ptr_next;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			rd_ptr <= '0;
		end else if (pop_ok) begin
			rd_ptr <= rd_ptr_next;
		end
	end

	// Occupancy count
	// Push and pop together leave it unchanged; when full only the pop
	// goes through, and an empty FIFO only sees the push
	always_ff @(posedge clk) begin
		if (reset) begin
			count <= '0;
		end else begin
			case ({push_ok, pop_ok})
				2'b10: begin
					count <= count + CNT_W'(1);
				end
				2'b01: begin
					count <= count - CNT_W'(1);
				end
				default: begin
					count <= count;
				end
			endcase
		end
	end

	// Batch storage
	always_ff @(posedge clk) begin
		if (push_ok) begin
			mem[wr_ptr] <= q.wdata;
		end
	end

endmodule

/* hdl/fill_batch_if.sv */
`timescale 1ns/100ps

`include "dfq_consts.svh"

interface fill_batch_if #(
	parameter type payload_t = dfq_pkg::fill_batch_t
);

	// Write side, driven by the producer
	logic     push;
	payload_t wdata;
	logic     full;

	// Read side, head of the queue
	payload_t rdata;
	logic     empty;
	logic     pop;

	// Storage side
	modport fifo (
		input  push,
		input  wdata,
		input  pop,
		output full,
		output rdata,
		output empty
	);

	// Consumer side, sees the head without delay
	modport drain (
		input  rdata,
		input  empty,
		output pop
	);

endinterface

/* hdl/dfq_pkg.sv */
`include "dfq_consts.svh"

package dfq_pkg;

	// One request bit per bank, bit i belongs to bank i
	typedef logic [`DFQ_BANKS-1:0] bank_mask_t;

	// Bank number as seen on the DRAM side
	typedef logic [$clog2(`DFQ_BANKS)-1:0] bank_idx_t;

	// Line address of a fill request
	typedef logic [`DFQ_ADDR_W-1:0] line_addr_t;

	// Everything the banks raise in one cycle
	// Addresses of banks whose mask bit is clear are don't-care
	typedef struct packed {
		bank_mask_t                  mask;
		line_addr_t [`DFQ_BANKS-1:0] addr;
	} fill_batch_t;

endpackage

/* hdl/dfq_consts.svh */
`ifndef DFQ_CONSTS_SVH
`define DFQ_CONSTS_SVH

// Banks that can raise a fill request in the same cycle
`define DFQ_BANKS 8

// Width of a cache line address sent to DRAM
`define DFQ_ADDR_W 32

// Batches held by the fill request FIFO
// Keep this a power of two
`define DFQ_DEPTH 4

`endif
